// File: src/robot_config.svh
`ifndef ROBOT_CONFIG_SVH
`define ROBOT_CONFIG_SVH

// IR remote key codes that select a drive mode
`define KEY_CAM     8'h0f
`define KEY_IR      8'h13
`define KEY_IDLE    8'h10

// Target direction codes from the vision front end
`define DIR_LEFT    3'b001
`define DIR_RIGHT   3'b010
`define DIR_AHEAD   3'b011

// Flip-flop stages on the asynchronous camera inputs
`define SYNC_STAGES 2

`endif

// File: src/robot_mode_pkg.sv
`default_nettype none

package robot_mode_pkg;

    // Top-level drive mode
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CAM  = 2'd1,
        IR   = 2'd2
    } mode_t;

    // Camera sub-machine, only leaves PAUSE in CAM mode
    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FOLLOW = 2'd1,
        PAUSE  = 2'd3
    } cam_state_t;

    typedef enum logic [2:0] {
        STOP   = 3'd0,
        LEFT   = 3'd1,
        RIGHT  = 3'd2,
        SLOW   = 3'd3,
        MEDIUM = 3'd4,
        FAST   = 3'd5
    } drive_cmd_t;

    // Pending mode request from the IR decoder
    typedef struct packed {
        logic  valid;
        mode_t mode;
    } mode_req_t;

endpackage

`default_nettype wire

// File: src/robot_io_pkg.sv
`default_nettype none

package robot_io_pkg;

    typedef logic [7:0] ir_key_t;      // Decoded IR key code
    typedef logic [2:0] cam_dir_t;     // Target direction
    typedef logic [1:0] speed_class_t; // 0 slow, 1 medium, 2 fast
    typedef logic [6:0] seg_t;         // Active low, bit 6 is g

    // One synchronized sample of the vision front end
    typedef struct packed {
        logic         target_seen;
        cam_dir_t     direction;
        speed_class_t speed;
    } vision_sample_t;

    // All eight digits, leftmost first
    typedef struct packed {
        seg_t hex7;
        seg_t hex6;
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } seg_frame_t;

endpackage

`default_nettype wire

// File: src/ir_command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "robot_config.svh"

module ir_command_decoder
    import robot_io_pkg::*;
    import robot_mode_pkg::*;
(
    input  logic      clk_50,
    input  logic      reset,
    input  ir_key_t   ir_key,
    input  logic      ir_valid,
    output logic      ir_ready,
    output mode_req_t mode_req,
    input  logic      req_ready
);

    logic  req_valid_q;    // Request register occupied
    mode_t req_mode_q;
    logic  key_hit;
    mode_t key_mode;
    logic  key_accept;

    // Map the three known keys to a mode
    always_comb begin
        key_hit  = 1'b1;
        key_mode = IDLE;
        case (ir_key)
            `KEY_CAM:  key_mode = CAM;
            `KEY_IR:   key_mode = IR;
            `KEY_IDLE: key_mode = IDLE;
            default:   key_hit = 1'b0;  // Unknown key, dropped
        endcase
    end

    assign ir_ready   = !req_valid_q;   // Stall the remote while full
    assign key_accept = ir_valid && ir_ready;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else if (key_accept && key_hit) begin
            req_valid_q <= 1'b1;
        end else if (req_valid_q && req_ready) begin
            req_valid_q <= 1'b0;        // Taken by the mode FSM
        end
    end

    always_ff @(posedge clk_50) begin
        if (key_accept && key_hit) begin
            req_mode_q <= key_mode;
        end
    end

    assign mode_req.valid = req_valid_q;
    assign mode_req.mode  = req_mode_q;

endmodule

`default_nettype wire

// File: src/vision_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "robot_config.svh"

module vision_sampler
    import robot_io_pkg::*;
(
    input  logic           clk_50,
    input  logic           reset,
    input  logic           orange_detected,
    input  cam_dir_t       cam_direction,
    input  speed_class_t   speed,
    output vision_sample_t vision
);

    vision_sample_t raw;
    vision_sample_t stage_q [`SYNC_STAGES];

    // Pack the camera pins before synchronizing
    always_comb begin
        raw.target_seen = orange_detected;
        raw.direction   = cam_direction;
        raw.speed       = speed;
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                stage_q[i] <= '0;           // Reads as no target
            end
        end else begin
            stage_q[0] <= raw;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // The machine samples the last stage directly
    assign vision = stage_q[`SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: src/drive_mode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "robot_config.svh"

module drive_mode_fsm
    import robot_io_pkg::*;
    import robot_mode_pkg::*;
(
    input  logic           clk_50,
    input  logic           reset,
    input  mode_req_t      mode_req,
    output logic           req_ready,
    input  vision_sample_t vision,
    output mode_t          mode,
    output cam_state_t     cam_state,
    output drive_cmd_t     drive_cmd,
    output logic           restart
);

    logic       acc_valid_q;    // Accepted request waiting to apply
    mode_t      acc_mode_q;
    logic       req_take;
    mode_t      next_mode;
    cam_state_t next_cam;
    drive_cmd_t next_drive;

    assign req_ready = !restart;    // One cycle of back-pressure per restart
    assign req_take  = mode_req.valid && req_ready;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            acc_valid_q <= 1'b0;
        end else begin
            acc_valid_q <= req_take;
        end
    end

    always_ff @(posedge clk_50) begin
        if (req_take) begin
            acc_mode_q <= mode_req.mode;
        end
    end

    // A repeat of the current mode falls through as no change
    assign next_mode = acc_valid_q ? acc_mode_q : mode;

    always_comb begin
        if (next_mode != CAM) begin
            next_cam = PAUSE;
        end else begin
            case (cam_state)
                PAUSE:   next_cam = SEARCH;     // Just entered CAM
                SEARCH:  next_cam = vision.target_seen ? FOLLOW : SEARCH;
                FOLLOW:  next_cam = vision.target_seen ? FOLLOW : SEARCH;
                default: next_cam = PAUSE;
            endcase
        end
    end

    // Drive command follows the camera state it is entering
    always_comb begin
        next_drive = STOP;
        case (next_cam)
            SEARCH: next_drive = RIGHT;         // Spin to look around
            FOLLOW: begin
                case (vision.direction)
                    `DIR_RIGHT: next_drive = RIGHT;
                    `DIR_LEFT:  next_drive = LEFT;
                    `DIR_AHEAD: begin
                        case (vision.speed)
                            2'd0:    next_drive = SLOW;
                            2'd1:    next_drive = MEDIUM;
                            2'd2:    next_drive = FAST;
                            default: next_drive = STOP;
                        endcase
                    end
                    default:    next_drive = STOP;
                endcase
            end
            default: next_drive = STOP;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            mode      <= IDLE;
            cam_state <= PAUSE;
            drive_cmd <= STOP;
            restart   <= 1'b0;
        end else begin
            mode      <= next_mode;
            cam_state <= next_cam;
            drive_cmd <= next_drive;
            restart   <= (next_mode != mode) || (next_cam != cam_state);
        end
    end

endmodule

`default_nettype wire

// File: src/status_display.sv
`timescale 1ns/1ps
`default_nettype none

module status_display
    import robot_io_pkg::*;
    import robot_mode_pkg::*;
(
    input  logic       clk_50,
    input  logic       reset,
    input  mode_t      mode,
    input  cam_state_t cam_state,
    input  drive_cmd_t drive_cmd,
    output seg_frame_t segments
);

    // Active-low patterns for every character the display uses
    function automatic seg_t glyph(input logic [7:0] ch);
        case (ch)
            "A":     glyph = 7'b0001000;
            "C":     glyph = 7'b1000110;
            "E":     glyph = 7'b0000110;
            "F":     glyph = 7'b0001110;
            "I":     glyph = 7'b1111001;
            "L":     glyph = 7'b1000111;
            "O":     glyph = 7'b1000000;
            "P":     glyph = 7'b0001100;
            "S":     glyph = 7'b0010010;
            "d":     glyph = 7'b0100001;
            "g":     glyph = 7'b0010000;
            "i":     glyph = 7'b1111011;
            "n":     glyph = 7'b0101011;
            "r":     glyph = 7'b0101111;
            "t":     glyph = 7'b0000111;
            default: glyph = 7'b1111111;   // Blank
        endcase
    endfunction

    function automatic seg_frame_t frame_of(input mode_t m, input cam_state_t c,
                                            input drive_cmd_t d);
        logic [15:0] mode_txt;
        logic [7:0]  cam_txt;
        logic [31:0] drive_txt;
        seg_frame_t  f;
        case (m)
            CAM:     mode_txt = "CA";
            IR:      mode_txt = "Ir";
            default: mode_txt = "Id";
        endcase
        case (c)
            SEARCH:  cam_txt = "S";
            FOLLOW:  cam_txt = "F";
            default: cam_txt = "P";
        endcase
        case (d)
            LEFT:    drive_txt = "LEFt";
            RIGHT:   drive_txt = "rigt";
            SLOW:    drive_txt = "SP S";
            MEDIUM:  drive_txt = "SP n";
            FAST:    drive_txt = "SP F";
            default: drive_txt = "StOP";
        endcase
        f.hex7 = glyph(mode_txt[15:8]);
        f.hex6 = glyph(mode_txt[7:0]);
        f.hex5 = glyph(" ");
        f.hex4 = glyph(cam_txt);
        f.hex3 = glyph(drive_txt[31:24]);
        f.hex2 = glyph(drive_txt[23:16]);
        f.hex1 = glyph(drive_txt[15:8]);
        f.hex0 = glyph(drive_txt[7:0]);
        return f;
    endfunction

    always_ff @(posedge clk_50) begin
        if (reset) begin
            segments <= frame_of(IDLE, PAUSE, STOP);   // Shows "Id P StOP"
        end else begin
            segments <= frame_of(mode, cam_state, drive_cmd);
        end
    end

endmodule

`default_nettype wire

// File: src/robot_control_top.sv
`timescale 1ns/1ps
`default_nettype none

module robot_control_top
    import robot_io_pkg::*;
    import robot_mode_pkg::*;
(
    input  logic         clk_50,
    input  logic         reset,
    input  ir_key_t      ir_key,
    input  logic         ir_valid,
    output logic         ir_ready,
    input  logic         orange_detected,
    input  cam_dir_t     cam_direction,
    input  speed_class_t speed,
    output mode_t        mode,
    output cam_state_t   cam_state,
    output drive_cmd_t   drive_cmd,
    output logic         restart,
    output seg_frame_t   segments
);

    mode_req_t      mode_req;
    logic           req_ready;
    vision_sample_t vision;

    ir_command_decoder u_decoder (
        .clk_50    (clk_50),
        .reset     (reset),
        .ir_key    (ir_key),
        .ir_valid  (ir_valid),
        .ir_ready  (ir_ready),
        .mode_req  (mode_req),
        .req_ready (req_ready)
    );

    vision_sampler u_sampler (
        .clk_50          (clk_50),
        .reset           (reset),
        .orange_detected (orange_detected),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .vision          (vision)
    );

    drive_mode_fsm u_fsm (
        .clk_50    (clk_50),
        .reset     (reset),
        .mode_req  (mode_req),
        .req_ready (req_ready),
        .vision    (vision),
        .mode      (mode),
        .cam_state (cam_state),
        .drive_cmd (drive_cmd),
        .restart   (restart)
    );

    status_display u_display (
        .clk_50    (clk_50),
        .reset     (reset),
        .mode      (mode),
        .cam_state (cam_state),
        .drive_cmd (drive_cmd),
        .segments  (segments)
    );

endmodule

`default_nettype wire

// File: verif/robot_control_sva.sv
`timescale 1ns/1ps
`default_nettype none

module robot_control_sva
    import robot_mode_pkg::*;
(
    input logic       clk_50,
    input logic       reset,
    input mode_req_t  mode_req,
    input logic       req_ready,
    input logic       restart,
    input mode_t      mode,
    input cam_state_t cam_state
);

    // Back-pressure after a mode change keeps mode changes apart
    mode_change_spacing: assert property (@(posedge clk_50) disable iff (reset)
        $changed(mode) |=> $stable(mode))
        else $error("mode changed on two consecutive edges");

    ready_vs_restart: assert property (@(posedge clk_50) disable iff (reset)
        req_ready == !restart)
        else $error("req_ready is not the inverse of restart");

    // Valid/ready hold rule on the request path
    req_held_stable: assert property (@(posedge clk_50) disable iff (reset)
        (mode_req.valid && !req_ready) |=> $stable(mode_req))
        else $error("mode_req changed while waiting");

    pause_outside_cam: assert property (@(posedge clk_50) disable iff (reset)
        (mode != CAM) |-> (cam_state == PAUSE))
        else $error("camera state left PAUSE outside CAM mode");

endmodule

bind drive_mode_fsm robot_control_sva sva0 (
    .clk_50    (clk_50),
    .reset     (reset),
    .mode_req  (mode_req),
    .req_ready (req_ready),
    .restart   (restart),
    .mode      (mode),
    .cam_state (cam_state)
);

`default_nettype wire

// File: verif/robot_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "robot_config.svh"

module robot_control_tb
    import robot_io_pkg::*;
    import robot_mode_pkg::*;
();

    localparam int KEY_COUNT    = 80;
    localparam int KEY_TIMEOUT  = 50;   // Cycles a key may wait for ir_ready
    localparam int IDLE_TIMEOUT = 20;

    logic         clk_50;
    logic         reset;
    ir_key_t      ir_key;
    logic         ir_valid;
    logic         ir_ready;
    logic         orange_detected;
    cam_dir_t     cam_direction;
    speed_class_t speed;
    mode_t        mode;
    cam_state_t   cam_state;
    drive_cmd_t   drive_cmd;
    logic         restart;
    seg_frame_t   segments;

    integer seed;
    integer vision_seed;
    int     mismatches;
    int     timeouts;
    int     other_errors;
    int     known_sent;     // Known keys handed over by the remote
    int     dut_taken;      // Requests taken by the DUT FSM
    bit     model_live;
    bit     key_go;         // Key transfers at the coming edge
    bit     timed_out;

    // Reference model, state after the last rising edge
    logic           m_req_valid;
    mode_t          m_req_mode;
    logic           m_pend_valid;
    mode_t          m_pend_mode;
    mode_t          m_mode;
    cam_state_t     m_cam;
    drive_cmd_t     m_drive;
    logic           m_restart;
    seg_frame_t     m_segments;
    vision_sample_t m_sync [`SYNC_STAGES];
    int             m_applied;

    robot_control_top dut0 (
        .clk_50          (clk_50),
        .reset           (reset),
        .ir_key          (ir_key),
        .ir_valid        (ir_valid),
        .ir_ready        (ir_ready),
        .orange_detected (orange_detected),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .mode            (mode),
        .cam_state       (cam_state),
        .drive_cmd       (drive_cmd),
        .restart         (restart),
        .segments        (segments)
    );

    always #20 clk_50 = ~clk_50;

    // Clear one bit per lit segment, a is bit 0
    function automatic seg_t lit_mask(input string segs);
        seg_t s;
        int   idx;
        s = '1;
        for (int i = 0; i < segs.len(); i++) begin
            idx = int'(segs[i]) - 97;
            s = s & ~(seg_t'(1) << idx);
        end
        return s;
    endfunction

    function automatic seg_t glyph_for(input byte c);
        case (c)
            "A":     return lit_mask("abcefg");
            "C":     return lit_mask("adef");
            "E":     return lit_mask("adefg");
            "F":     return lit_mask("aefg");
            "I":     return lit_mask("bc");
            "L":     return lit_mask("def");
            "O":     return lit_mask("abcdef");
            "P":     return lit_mask("abefg");
            "S":     return lit_mask("acdfg");
            "d":     return lit_mask("bcdeg");
            "g":     return lit_mask("abcdfg");
            "i":     return lit_mask("c");
            "n":     return lit_mask("ceg");
            "r":     return lit_mask("eg");
            "t":     return lit_mask("defg");
            default: return '1;             // Blank digit
        endcase
    endfunction

    function automatic seg_frame_t letter_frame(input mode_t m, input cam_state_t c,
                                                input drive_cmd_t d);
        string      mt;
        string      ct;
        string      dt;
        seg_frame_t f;
        case (m)
            CAM:     mt = "CA";
            IR:      mt = "Ir";
            default: mt = "Id";
        endcase
        case (c)
            SEARCH:  ct = "S";
            FOLLOW:  ct = "F";
            default: ct = "P";
        endcase
        case (d)
            LEFT:    dt = "LEFt";
            RIGHT:   dt = "rigt";
            SLOW:    dt = "SP S";
            MEDIUM:  dt = "SP n";
            FAST:    dt = "SP F";
            default: dt = "StOP";
        endcase
        f.hex7 = glyph_for(mt[0]);
        f.hex6 = glyph_for(mt[1]);
        f.hex5 = glyph_for(" ");
        f.hex4 = glyph_for(ct[0]);
        f.hex3 = glyph_for(dt[0]);
        f.hex2 = glyph_for(dt[1]);
        f.hex1 = glyph_for(dt[2]);
        f.hex0 = glyph_for(dt[3]);
        return f;
    endfunction

    function automatic mode_req_t decode_key(input ir_key_t k);
        mode_req_t r;
        r.valid = 1'b1;
        r.mode  = IDLE;
        if (k == `KEY_CAM) begin
            r.mode = CAM;
        end else if (k == `KEY_IR) begin
            r.mode = IR;
        end else if (k != `KEY_IDLE) begin
            r.valid = 1'b0;                 // Not one of the three keys
        end
        return r;
    endfunction

    function automatic cam_state_t cam_next(input mode_t nm, input cam_state_t c,
                                            input logic seen);
        if (nm != CAM) begin
            return PAUSE;
        end
        if (c == PAUSE) begin
            return SEARCH;
        end
        return seen ? FOLLOW : SEARCH;
    endfunction

    function automatic drive_cmd_t drive_for(input cam_state_t c, input vision_sample_t v);
        if (c == SEARCH) begin
            return RIGHT;
        end
        if (c != FOLLOW || v.direction == `DIR_LEFT) begin
            return (c == FOLLOW) ? LEFT : STOP;
        end
        if (v.direction == `DIR_RIGHT) begin
            return RIGHT;
        end
        if (v.direction != `DIR_AHEAD || v.speed == 2'd3) begin
            return STOP;
        end
        return (v.speed == 2'd0) ? SLOW : (v.speed == 2'd1) ? MEDIUM : FAST;
    endfunction

    task automatic mode_check(input mode_t got, input mode_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic cam_check(input cam_state_t got, input cam_state_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic drive_check(input drive_cmd_t got, input drive_cmd_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic frame_check(input seg_frame_t got, input seg_frame_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bit_check(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Compare at the falling edge, then advance the model over the next rising edge
    always @(negedge clk_50) begin : model_step
        mode_req_t      hit;
        logic           take;
        mode_t          nm;
        cam_state_t     nc;
        vision_sample_t raw;
        if (model_live) begin
            mode_check(mode, m_mode, "mode");
            cam_check(cam_state, m_cam, "cam_state");
            drive_check(drive_cmd, m_drive, "drive_cmd");
            bit_check(restart, m_restart, "restart");
            bit_check(ir_ready, !m_req_valid, "ir_ready");
            frame_check(segments, m_segments, "segments");
            if (!reset && dut0.mode_req.valid && dut0.req_ready) begin
                dut_taken++;
            end
        end
        key_go = ir_valid && !m_req_valid && !reset;
        if (reset) begin
            m_req_valid  = 1'b0;
            m_pend_valid = 1'b0;
            m_mode       = IDLE;
            m_cam        = PAUSE;
            m_drive      = STOP;
            m_restart    = 1'b0;
            m_segments   = letter_frame(IDLE, PAUSE, STOP);
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                m_sync[i] = '0;
            end
            model_live = 1'b1;
        end else begin
            hit  = decode_key(ir_key);
            take = m_req_valid && !m_restart;       // FSM stalls during restart
            nm   = m_pend_valid ? m_pend_mode : m_mode;
            nc   = cam_next(nm, m_cam, m_sync[`SYNC_STAGES-1].target_seen);
            m_segments = letter_frame(m_mode, m_cam, m_drive);
            m_drive    = drive_for(nc, m_sync[`SYNC_STAGES-1]);
            m_restart  = (nm != m_mode) || (nc != m_cam);
            m_mode     = nm;
            m_cam      = nc;
            m_pend_valid = take;
            if (take) begin
                m_pend_mode = m_req_mode;
                m_applied++;
            end
            if (key_go && hit.valid) begin
                m_req_valid = 1'b1;
                m_req_mode  = hit.mode;
            end else if (take) begin
                m_req_valid = 1'b0;
            end
            for (int i = `SYNC_STAGES - 1; i > 0; i--) begin
                m_sync[i] = m_sync[i-1];
            end
            raw.target_seen = orange_detected;
            raw.direction   = cam_direction;
            raw.speed       = speed;
            m_sync[0] = raw;
        end
    end

    // Camera inputs wander with long enough runs to reach FOLLOW
    always @(posedge clk_50) begin : vision_stim
        logic [31:0] r;
        if (!reset) begin
            r = $random(vision_seed);
            if (r[1:0] == 2'd0) begin
                orange_detected <= !orange_detected;
            end
            if (r[4:2] == 3'd0) begin
                cam_direction <= r[7:5];
            end
            if (r[10:8] == 3'd0) begin
                speed <= r[12:11];
            end
        end
    end

    task automatic send_key(input ir_key_t key);
        int        waited;
        mode_req_t hit;
        hit      = decode_key(key);
        ir_key   <= key;
        ir_valid <= 1'b1;
        waited   = 0;
        do begin
            @(posedge clk_50);
            waited++;
        end while (!key_go && waited < KEY_TIMEOUT);
        if (key_go) begin
            if (hit.valid) begin
                known_sent++;
            end
        end else begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timeout: key %h was not accepted within %0d cycles", key, KEY_TIMEOUT);
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((m_req_valid || m_pend_valid || m_restart) && waited < IDLE_TIMEOUT) begin
            @(posedge clk_50);
            waited++;
        end
        if (m_req_valid || m_pend_valid || m_restart) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timeout: pending mode requests did not drain");
        end
    endtask

    initial begin : main
        logic [31:0] r;
        ir_key_t     key;
        int          gap;
        seed            = 32'hcb168b2e;
        vision_seed     = seed ^ 32'h0000ffff;
        mismatches      = 0;
        timeouts        = 0;
        other_errors    = 0;
        known_sent      = 0;
        dut_taken       = 0;
        m_applied       = 0;
        model_live      = 1'b0;
        key_go          = 1'b0;
        timed_out       = 1'b0;
        clk_50          = 1'b0;
        reset           = 1'b1;
        ir_key          = '0;
        ir_valid        = 1'b0;
        orange_detected = 1'b0;
        cam_direction   = '0;
        speed           = '0;
        repeat (4) @(posedge clk_50);
        reset <= 1'b0;
        for (int n = 0; n < KEY_COUNT && !timed_out; n++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: key = `KEY_CAM;
                3'd3:             key = `KEY_IR;
                3'd4:             key = `KEY_IDLE;
                default:          key = r[15:8];    // Mostly unknown codes
            endcase
            send_key(key);
            gap = r[21] ? 0 : int'(r[20:16]);       // Half of the keys back to back
            if (gap > 0) begin
                ir_valid <= 1'b0;
                repeat (gap) @(posedge clk_50);
            end
        end
        ir_valid <= 1'b0;
        wait_idle();
        if (!timed_out && (known_sent != m_applied || known_sent != dut_taken)) begin
            other_errors++;
            $display("Lost requests: %0d known keys sent, model took %0d, DUT took %0d",
                     known_sent, m_applied, dut_taken);
        end
        $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
                 other_errors);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: robot_control.f
+incdir+src
src/robot_mode_pkg.sv
src/robot_io_pkg.sv
src/ir_command_decoder.sv
src/vision_sampler.sv
src/drive_mode_fsm.sv
src/status_display.sv
src/robot_control_top.sv
verif/robot_control_sva.sv
verif/robot_control_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module robot_control_tb \
    -f robot_control.f \
    --Mdir obj_dir -o Vrobot_control_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrobot_control_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
